// ==== verilog/ifu_pkg.sv ====
package ifu_pkg;

  // byte address on the instruction bus, also used for every pc
  typedef logic [31:0] addr_t;

  // raw instruction word as returned by the bus
  typedef logic [31:0] inst_t;

  // fetch machine
  //   idle   nothing outstanding, nothing held (only after reset)
  //   access one request on the bus, waiting for ack
  //   flush  request on the bus but redirected, its ack is dropped
  //   hold   instruction presented to decode
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_ACCESS = 2'd1,
    ST_FLUSH  = 2'd2,
    ST_HOLD   = 2'd3
  } fetch_state_t;

  // pc step between sequential fetches
  localparam addr_t INST_BYTES = 32'd4;

endpackage

// ==== verilog/ifu_fetch_addr.sv ====
module ifu_fetch_addr #(
  parameter ifu_pkg::addr_t RESET_PC = 32'h0000_0100
) (
  input  logic           clk,
  input  logic           rst,

  input  logic           i_issue,
  input  logic           i_use_target,
  input  ifu_pkg::addr_t i_target,

  output ifu_pkg::addr_t o_req_addr,

  output logic           o_instbus_req,
  output ifu_pkg::addr_t o_instbus_addr
);

  import ifu_pkg::*;

  // next sequential fetch address
  addr_t pc_seq;

  // address of the last request, held on the bus
  addr_t req_addr;
  logic  req;

  addr_t fetch_addr;

  // redirect target wins over the sequential pc
  assign fetch_addr = i_use_target ? i_target : pc_seq;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_seq   <= RESET_PC;
      req_addr <= RESET_PC;
      req      <= 1'b0;
    end else begin
      req <= i_issue;
      if (i_issue) begin
        req_addr <= fetch_addr;
        pc_seq   <= fetch_addr + INST_BYTES;
      end
    end
  end

  assign o_req_addr     = req_addr;
  assign o_instbus_req  = req;
  assign o_instbus_addr = req_addr;

  // one request at a time, each one a single-cycle pulse
  req_single_pulse: assert property (
    @(posedge clk) disable iff (rst)
    o_instbus_req |=> !o_instbus_req
  ) else $error("instbus request held for more than one cycle");

  // fetches are always word aligned
  addr_aligned: assert property (
    @(posedge clk) disable iff (rst)
    o_instbus_addr[1:0] == 2'b00
  ) else $error("misaligned instbus address %h", o_instbus_addr);

endmodule

// ==== verilog/ifu_fetch_ctrl.sv ====
module ifu_fetch_ctrl (
  input  logic           clk,
  input  logic           rst,

  // execute stage
  input  logic           i_alu_vld,
  input  logic           i_alu_trap,
  input  logic           i_alu_br_miss,
  input  ifu_pkg::addr_t i_alu_pc_next,

  // decode stage
  input  logic           i_idu_freeze,

  // instruction bus return
  input  logic           i_instbus_ack,
  input  ifu_pkg::inst_t i_instbus_data,

  // address side
  input  ifu_pkg::addr_t i_req_addr,
  output logic           o_issue,
  output logic           o_use_target,
  output ifu_pkg::addr_t o_target,

  // to decode
  output logic           o_ifu_vld,
  output ifu_pkg::inst_t o_ifu_inst,
  output ifu_pkg::addr_t o_ifu_inst_pc
);

  import ifu_pkg::*;

  fetch_state_t state;
  fetch_state_t state_nxt;

  logic  redirect;
  logic  load_inst;
  logic  load_pend;

  // target saved while the flushed access drains
  addr_t pend_target;

  logic  vld;
  inst_t inst;
  addr_t inst_pc;

  // branch miss or trap from execute
  assign redirect = i_alu_vld & (i_alu_trap | i_alu_br_miss);

  // a fresh redirect in flush replaces the saved target
  assign o_target = (state == ST_FLUSH && !redirect) ? pend_target : i_alu_pc_next;

  always_comb begin
    state_nxt    = state;
    o_issue      = 1'b0;
    o_use_target = 1'b0;
    load_inst    = 1'b0;
    load_pend    = 1'b0;

    unique case (state)
      ST_IDLE: begin
        // first fetch out of reset
        o_issue      = 1'b1;
        o_use_target = redirect;
        state_nxt    = ST_ACCESS;
      end

      ST_ACCESS: begin
        if (i_instbus_ack && redirect) begin
          // data is stale, go straight to the target
          o_issue      = 1'b1;
          o_use_target = 1'b1;
          state_nxt    = ST_ACCESS;
        end else if (i_instbus_ack) begin
          load_inst = 1'b1;
          state_nxt = ST_HOLD;
        end else if (redirect) begin
          load_pend = 1'b1;
          state_nxt = ST_FLUSH;
        end
      end

      ST_FLUSH: begin
        if (i_instbus_ack) begin
          // drop this ack and fetch the target
          o_issue      = 1'b1;
          o_use_target = 1'b1;
          state_nxt    = ST_ACCESS;
        end else if (redirect) begin
          load_pend = 1'b1;
        end
      end

      ST_HOLD: begin
        if (redirect) begin
          o_issue      = 1'b1;
          o_use_target = 1'b1;
          state_nxt    = ST_ACCESS;
        end else if (!i_idu_freeze) begin
          // accepted by decode, fetch the next one
          o_issue   = 1'b1;
          state_nxt = ST_ACCESS;
        end
      end

      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      vld   <= 1'b0;
    end else begin
      state <= state_nxt;
      // valid rises with a captured instruction, falls when the next fetch goes out
      if (load_inst) begin
        vld <= 1'b1;
      end else if (o_issue) begin
        vld <= 1'b0;
      end
    end
  end

  // instruction and its pc, captured with the ack
  always_ff @(posedge clk) begin
    if (load_inst) begin
      inst    <= i_instbus_data;
      inst_pc <= i_req_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (load_pend) begin
      pend_target <= i_alu_pc_next;
    end
  end

  assign o_ifu_vld     = vld;
  assign o_ifu_inst    = inst;
  assign o_ifu_inst_pc = inst_pc;

  // bus must only answer an outstanding request
  ack_when_outstanding: assert property (
    @(posedge clk) disable iff (rst)
    i_instbus_ack |-> (state == ST_ACCESS || state == ST_FLUSH)
  ) else $error("instbus ack with no request outstanding");

  // valid to decode tracks the hold state
  vld_in_hold: assert property (
    @(posedge clk) disable iff (rst)
    o_ifu_vld == (state == ST_HOLD)
  ) else $error("ifu valid out of step with fetch state");

endmodule

// ==== verilog/riscv_ifu.sv ====
module riscv_ifu #(
  parameter ifu_pkg::addr_t RESET_PC = 32'h0000_0100
) (
  input  logic           clk,
  input  logic           rst,

  // execute stage
  input  logic           i_alu_vld,
  input  logic           i_alu_trap,
  input  logic           i_alu_br_miss,
  input  ifu_pkg::addr_t i_alu_pc_next,

  // decode stage
  input  logic           i_idu_freeze,
  output logic           o_ifu_vld,
  output ifu_pkg::inst_t o_ifu_inst,
  output ifu_pkg::addr_t o_ifu_inst_pc,

  // instruction bus
  output logic           o_instbus_req,
  output ifu_pkg::addr_t o_instbus_addr,
  input  logic           i_instbus_ack,
  input  ifu_pkg::inst_t i_instbus_data
);

  import ifu_pkg::*;

  logic  issue;
  logic  use_target;
  addr_t target;
  addr_t req_addr;

  // fetch sequencing and the decode register
  ifu_fetch_ctrl ctrl_i (
    .clk            (clk),
    .rst            (rst),
    .i_alu_vld      (i_alu_vld),
    .i_alu_trap     (i_alu_trap),
    .i_alu_br_miss  (i_alu_br_miss),
    .i_alu_pc_next  (i_alu_pc_next),
    .i_idu_freeze   (i_idu_freeze),
    .i_instbus_ack  (i_instbus_ack),
    .i_instbus_data (i_instbus_data),
    .i_req_addr     (req_addr),
    .o_issue        (issue),
    .o_use_target   (use_target),
    .o_target       (target),
    .o_ifu_vld      (o_ifu_vld),
    .o_ifu_inst     (o_ifu_inst),
    .o_ifu_inst_pc  (o_ifu_inst_pc)
  );

  // pc and bus request
  ifu_fetch_addr #(
    .RESET_PC (RESET_PC)
  ) addr_i (
    .clk            (clk),
    .rst            (rst),
    .i_issue        (issue),
    .i_use_target   (use_target),
    .i_target       (target),
    .o_req_addr     (req_addr),
    .o_instbus_req  (o_instbus_req),
    .o_instbus_addr (o_instbus_addr)
  );

endmodule

// ==== sim/tb_riscv_ifu.sv ====
module tb_riscv_ifu;

  import ifu_pkg::*;

  localparam addr_t RESET_PC   = 32'h0000_0100;
  localparam int    TIMEOUT    = 64;
  localparam int    STIM_WORDS = 256;

  logic  clk;
  logic  rst;
  logic  i_alu_vld;
  logic  i_alu_trap;
  logic  i_alu_br_miss;
  addr_t i_alu_pc_next;
  logic  i_idu_freeze;
  logic  o_ifu_vld;
  inst_t o_ifu_inst;
  addr_t o_ifu_inst_pc;
  logic  o_instbus_req;
  addr_t o_instbus_addr;
  logic  i_instbus_ack;
  inst_t i_instbus_data;

  // four words per event, op code first
  logic [31:0] stim_mem [STIM_WORDS];
  addr_t       req_q [$];
  addr_t       exp_pc;
  inst_t       held_inst;
  addr_t       held_pc;
  logic        held;
  logic        abort;
  logic [31:0] seed;
  int          mismatches;
  int          failures;

  riscv_ifu #(.RESET_PC(RESET_PC)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic compare_inst(input string name, input inst_t exp, input inst_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    failures++;
  endtask

  // one cycle; inputs change one unit after the edge, requests are logged here
  task automatic step();
    @(posedge clk);
    #1;
    if (!rst && o_instbus_req) req_q.push_back(o_instbus_addr);
  endtask

  task automatic wait_request(output addr_t addr);
    int n;
    n = 0;
    addr = '0;
    while (req_q.size() == 0 && n < TIMEOUT) begin
      step();
      n++;
    end
    if (req_q.size() == 0) begin
      report_failure("timeout, the fetch unit never put a request on the bus");
      abort = 1'b1;
    end else begin
      addr = req_q.pop_front();
    end
  endtask

  // bus model, ack comes lat cycles after the request cycle
  task automatic bus_respond(input inst_t data, input int lat);
    repeat (lat) step();
    i_instbus_ack  = 1'b1;
    i_instbus_data = data;
    step();
    i_instbus_ack  = 1'b0;
    i_instbus_data = '0;
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    while (!o_ifu_vld && n < TIMEOUT) begin
      step();
      n++;
    end
  endtask

  task automatic release_held();
    if (held) begin
      i_idu_freeze = 1'b0;
      step();
      i_idu_freeze = 1'b1;
      held = 1'b0;
      if (o_ifu_vld) report_failure("valid still high after decode took the instruction");
    end
  endtask

  task automatic fetch_instruction(input inst_t data, input int lat);
    addr_t addr;
    release_held();
    wait_request(addr);
    if (abort) return;
    compare_addr("fetch address", exp_pc, addr);
    bus_respond(data, lat);
    wait_valid();
    if (!o_ifu_vld) begin
      report_failure("timeout, acked instruction never presented to decode");
      abort = 1'b1;
      return;
    end
    compare_inst("presented instruction", data, o_ifu_inst);
    compare_addr("presented pc", exp_pc, o_ifu_inst_pc);
    held_inst = data;
    held_pc   = exp_pc;
    held      = 1'b1;
    exp_pc    = exp_pc + INST_BYTES;
  endtask

  task automatic hold_frozen(input int cycles);
    if (!held) begin
      report_failure("freeze event with no instruction held");
      return;
    end
    repeat (cycles) begin
      step();
      if (!o_ifu_vld) report_failure("valid dropped while decode was frozen");
      if (req_q.size() != 0) report_failure("bus request issued while decode was frozen");
      compare_inst("frozen instruction", held_inst, o_ifu_inst);
      compare_addr("frozen pc", held_pc, o_ifu_inst_pc);
    end
  endtask

  // kind 0 is a branch miss, kind 1 a trap
  task automatic drive_redirect(input logic [31:0] kind, input addr_t target);
    i_alu_vld     = 1'b1;
    i_alu_trap    = kind[0];
    i_alu_br_miss = !kind[0];
    i_alu_pc_next = target;
    step();
    i_alu_vld     = 1'b0;
    i_alu_trap    = 1'b0;
    i_alu_br_miss = 1'b0;
    i_alu_pc_next = '0;
  endtask

  task automatic redirect_access(input logic [31:0] kind, input addr_t target, input inst_t stale);
    addr_t addr;
    int    lat;
    release_held();
    wait_request(addr);
    if (abort) return;
    compare_addr("flushed fetch address", exp_pc, addr);
    drive_redirect(kind, target);
    seed = next_rand(seed);
    lat  = 1 + int'((seed >> 16) % 32'd4);
    repeat (lat) begin
      step();
      if (req_q.size() != 0) report_failure("target requested before the flushed ack");
      if (o_ifu_vld) report_failure("valid raised during a flushed access");
    end
    // late ack of the flushed access
    bus_respond(stale, 0);
    if (o_ifu_vld) report_failure("flushed instruction presented to decode");
    exp_pc = target;
  endtask

  initial begin
    int          idx;
    int          lat;
    logic [31:0] op;
    rst            = 1'b1;
    i_alu_vld      = 1'b0;
    i_alu_trap     = 1'b0;
    i_alu_br_miss  = 1'b0;
    i_alu_pc_next  = '0;
    i_idu_freeze   = 1'b1;
    i_instbus_ack  = 1'b0;
    i_instbus_data = '0;
    seed           = 32'h32d5_fdd4;
    mismatches     = 0;
    failures       = 0;
    abort          = 1'b0;
    held           = 1'b0;
    exp_pc         = RESET_PC;
    for (int i = 0; i < STIM_WORDS; i++) stim_mem[i] = '0;
    $readmemh("sim/ifu_stim.txt", stim_mem);
    if (stim_mem[0] == 32'd0) report_failure("stimulus file is empty or missing");
    repeat (4) step();
    rst = 1'b0;
    idx = 0;
    while (!abort && idx + 3 < STIM_WORDS && stim_mem[idx] != 32'd0) begin
      op = stim_mem[idx];
      case (op)
        32'd1: begin
          lat = int'(stim_mem[idx + 2]);
          if (lat == 0) begin
            seed = next_rand(seed);
            lat  = 1 + int'((seed >> 16) % 32'd5);
          end
          fetch_instruction(stim_mem[idx + 1], lat);
        end
        32'd2: hold_frozen(int'(stim_mem[idx + 1]));
        32'd3: begin
          if (!held) begin
            report_failure("hold redirect with no instruction held");
          end else begin
            drive_redirect(stim_mem[idx + 1], stim_mem[idx + 2]);
            held = 1'b0;
            if (o_ifu_vld) report_failure("instruction not withdrawn on redirect");
            exp_pc = stim_mem[idx + 2];
          end
        end
        32'd4: redirect_access(stim_mem[idx + 1], stim_mem[idx + 2], stim_mem[idx + 3]);
        32'd5: begin
          // long run, data and latency both from the generator
          for (int k = 0; k < int'(stim_mem[idx + 1]) && !abort; k++) begin
            seed = next_rand(seed);
            lat  = 1 + int'((seed >> 16) % 32'd6);
            fetch_instruction(next_rand(seed ^ 32'h5a5a_0f0f), lat);
          end
        end
        default: report_failure("unknown event code in stimulus file");
      endcase
      idx += 4;
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0 && !abort) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== sim/ifu_stim.txt ====
// columns: op arg_a arg_b arg_c, one fetch unit event per line
// op 1 fetch (a word, b ack latency, 0 = random)  op 2 freeze (a cycles)
// op 3 hold redirect (a kind 0 miss 1 trap, b target)  op 4 access redirect (c stale data)
// op 5 random run (a count)
01 00000013 00000001 00000000 // 0x100 nop
01 00100093 00000002 00000000 // 0x104
01 00200113 00000003 00000000 // 0x108
02 00000005 00000000 00000000
01 002081b3 00000001 00000000 // 0x10c
02 00000003 00000000 00000000
01 00312023 00000000 00000000 // 0x110
03 00000000 00000400 00000000 // branch miss in hold
01 fe0008e3 00000002 00000000 // 0x400
01 0000006f 00000001 00000000 // 0x404
03 00000001 00000200 00000000 // trap in hold
01 00000073 00000000 00000000 // 0x200
04 00000000 00000800 deadbeef // miss while 0x204 is on the bus
01 00410213 00000003 00000000 // 0x800
01 00520293 00000000 00000000 // 0x804
04 00000001 00000180 badc0ffe // trap while 0x808 is on the bus
01 00630313 00000001 00000000 // 0x180
02 00000004 00000000 00000000
05 00000040 00000000 00000000
03 00000000 00000600 00000000
04 00000001 00000700 0badf00d // flush the target fetch itself
01 00740393 00000002 00000000 // 0x700
01 00850413 00000001 00000000 // 0x704

// ==== tb.f ====
verilog/ifu_pkg.sv
verilog/ifu_fetch_addr.sv
verilog/ifu_fetch_ctrl.sv
verilog/riscv_ifu.sv
sim/tb_riscv_ifu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch unit testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_riscv_ifu -f tb.f -o tb_riscv_ifu \
  && ./obj_dir/tb_riscv_ifu > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Verification passed" sim.log || exit 1
